// ==== filelist.f ====
src/puzzleDisplayPkg.sv
src/scanTimer.sv
src/cursorControl.sv
src/modSquareGenerator.sv
src/pixelColorMixer.sv
src/puzzleDisplayTop.sv
verif/clockGen.sv
verif/puzzleDisplay_assert.sv
verif/puzzleDisplayTb.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module puzzleDisplayTb \
    -f filelist.f > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/VpuzzleDisplayTb > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log && exit 0 || { echo "no result in sim.log"; exit 1; }

// ==== src/cursorControl.sv ====
`timescale 1ns/100ps

module cursorControl import puzzleDisplayPkg::*; (
    input  logic clk,
    input  logic rstN,
    input  logic frameStart,
    input  logic moveUp,
    input  logic moveDown,
    input  logic moveLeft,
    input  logic moveRight,
    output logic modRow,
    output logic modCol
);

    cursorState_t state;
    cursorState_t stateNext;

    // pending move, bit 1 is the axis (0 row, 1 col), bit 0 the new index
    logic [1:0] pendingMove;
    logic [1:0] moveCode;
    logic       anyMove;

    assign anyMove = moveUp | moveDown | moveLeft | moveRight;

    // encode the incoming pulse
    // simultaneous pulses resolve up, down, left, right
    always_comb begin
        if (moveUp) begin
            moveCode = 2'b01;
        end else if (moveDown) begin
            moveCode = 2'b00;
        end else if (moveLeft) begin
            moveCode = 2'b11;
        end else begin
            moveCode = 2'b10;
        end
    end

    // next state
    always_comb begin
        stateNext = state;
        case (state)
            cursorIdle: begin
                // only a move seen here is taken
                if (anyMove) begin
                    stateNext = cursorPending;
                end
            end
            cursorPending: begin
                // hold until the raster is back at the top
                if (frameStart) begin
                    stateNext = cursorApply;
                end
            end
            cursorApply: begin
                stateNext = cursorIdle;
            end
            default: begin
                stateNext = cursorIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= cursorIdle;
        end else begin
            state <= stateNext;
        end
    end

    // capture the move that started the pending cycle
    always_ff @(posedge clk) begin
        if (state == cursorIdle && anyMove) begin
            pendingMove <= moveCode;
        end
    end

    // saturating update, one axis per move
    always_ff @(posedge clk) begin
        if (!rstN) begin
            modRow <= 1'b0;
            modCol <= 1'b0;
        end else if (state == cursorApply) begin
            if (pendingMove[1]) begin
                modCol <= pendingMove[0];
            end else begin
                modRow <= pendingMove[0];
            end
        end
    end

endmodule

// ==== src/modSquareGenerator.sv ====
`timescale 1ns/100ps

module modSquareGenerator import puzzleDisplayPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic [xWidth-1:0] x,
    input  logic [yWidth-1:0] y,
    input  logic              modRow,
    input  logic              modCol,
    output logic              modSquaresPixel,
    output logic              modHighlightPixel
);

    logic squaresDetect;
    logic highlightDetect;

    // tile windows, all bounds exclusive
    always_comb begin
        int loX;
        int loY;
        squaresDetect = 1'b0;
        for (int i = 0; i < tilesPerAxis; i++) begin
            for (int j = 0; j < tilesPerAxis; j++) begin
                loX = tileOrigin + tileStep * i;
                loY = tileOrigin + tileStep * j;
                if (int'(x) > loX && int'(x) < loX + tileSize &&
                    int'(y) > loY && int'(y) < loY + tileSize) begin
                    squaresDetect = 1'b1;
                end
            end
        end
    end

    // highlight window around the selected tile
    // column picks the x center, row picks the y center
    always_comb begin
        int centerX;
        int centerY;
        centerX = highlightCenterBase - tileStep * int'(modCol);
        centerY = highlightCenterBase - tileStep * int'(modRow);
        highlightDetect = (int'(x) > centerX - highlightHalf) &&
                          (int'(x) < centerX + highlightHalf) &&
                          (int'(y) > centerY - highlightHalf) &&
                          (int'(y) < centerY + highlightHalf);
    end

    // one cycle of latency on both marks
    always_ff @(posedge clk) begin
        if (!rstN) begin
            modSquaresPixel <= 1'b0;
            modHighlightPixel <= 1'b0;
        end else begin
            modSquaresPixel <= squaresDetect;
            modHighlightPixel <= highlightDetect;
        end
    end

endmodule

// ==== src/pixelColorMixer.sv ====
`timescale 1ns/100ps

module pixelColorMixer import puzzleDisplayPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   modSquaresPixel,
    input  logic   modHighlightPixel,
    input  logic   active,
    input  logic   hSyncRaw,
    input  logic   vSyncRaw,
    output rgb12_t rgb,
    output logic   hSync,
    output logic   vSync
);

    // first delay stage, lines up with the generator marks
    logic activeD1;
    logic hSyncD1;
    logic vSyncD1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            activeD1 <= 1'b0;
            hSyncD1 <= 1'b1;
            vSyncD1 <= 1'b1;
        end else begin
            activeD1 <= active;
            hSyncD1 <= hSyncRaw;
            vSyncD1 <= vSyncRaw;
        end
    end

    // second stage drives the pins
    // highlight wins over tile, tile over background, black in blanking
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rgb <= colorBackground;
            hSync <= 1'b1;
            vSync <= 1'b1;
        end else begin
            hSync <= hSyncD1;
            vSync <= vSyncD1;
            if (!activeD1) begin
                rgb <= 12'h000;
            end else if (modHighlightPixel) begin
                rgb <= colorHighlight;
            end else if (modSquaresPixel) begin
                rgb <= colorTile;
            end else begin
                rgb <= colorBackground;
            end
        end
    end

endmodule

// ==== src/puzzleDisplayPkg.sv ====
package puzzleDisplayPkg;

    // counter widths for the pixel and line counters
    // the line counter has to reach vTotal - 1
    localparam int xWidth = 9;
    localparam int yWidth = 9;

    // visible pixels and clocks per line
    localparam int hActive = 320;
    localparam int hTotal = 400;

    // visible lines and lines per frame
    localparam int vActive = 240;
    localparam int vTotal = 262;

    // hsync is low for x in [hSyncStart, hSyncEnd)
    localparam int hSyncStart = 328;
    localparam int hSyncEnd = 376;

    // vsync is low for y in [vSyncStart, vSyncEnd)
    localparam int vSyncStart = 244;
    localparam int vSyncEnd = 246;

    // tile k spans (tileOrigin + tileStep*k, tileOrigin + tileStep*k + tileSize)
    localparam int tileOrigin = 20;
    localparam int tileStep = 110;
    localparam int tileSize = 90;

    // number of tiles on each axis
    localparam int tilesPerAxis = 2;

    // highlight center is highlightCenterBase - tileStep*index on each axis
    // index 0 lands on the right or bottom tile
    localparam int highlightCenterBase = 175;
    localparam int highlightHalf = 50;

    // 4-4-4 color word with red in the top nibble
    typedef logic [11:0] rgb12_t;

    localparam rgb12_t colorBackground = 12'h000;
    localparam rgb12_t colorTile = 12'h888;
    localparam rgb12_t colorHighlight = 12'hFF0;

    // cursor update FSM
    // idle waits for a move, pending waits for frame start,
    // apply writes the new row or column
    typedef enum logic [1:0] {
        cursorIdle,
        cursorPending,
        cursorApply
    } cursorState_t;

endpackage

// ==== src/puzzleDisplayTop.sv ====
`timescale 1ns/100ps

module puzzleDisplayTop import puzzleDisplayPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              moveUp,
    input  logic              moveDown,
    input  logic              moveLeft,
    input  logic              moveRight,
    output logic [xWidth-1:0] pixelX,
    output logic [yWidth-1:0] pixelY,
    output rgb12_t            rgb,
    output logic              hSync,
    output logic              vSync
);

    // raster position and timing
    logic [xWidth-1:0] x;
    logic [yWidth-1:0] y;
    logic              active;
    logic              frameStart;
    logic              hSyncRaw;
    logic              vSyncRaw;

    // selected tile
    logic modRow;
    logic modCol;

    // per-pixel marks, one cycle behind x and y
    logic modSquaresPixel;
    logic modHighlightPixel;

    scanTimer i_scanTimer (
        .clk        (clk),
        .rstN       (rstN),
        .x          (x),
        .y          (y),
        .active     (active),
        .frameStart (frameStart),
        .hSyncRaw   (hSyncRaw),
        .vSyncRaw   (vSyncRaw)
    );

    // cursor only moves right after a frame start
    cursorControl i_cursorControl (
        .clk        (clk),
        .rstN       (rstN),
        .frameStart (frameStart),
        .moveUp     (moveUp),
        .moveDown   (moveDown),
        .moveLeft   (moveLeft),
        .moveRight  (moveRight),
        .modRow     (modRow),
        .modCol     (modCol)
    );

    modSquareGenerator i_modSquareGenerator (
        .clk               (clk),
        .rstN              (rstN),
        .x                 (x),
        .y                 (y),
        .modRow            (modRow),
        .modCol            (modCol),
        .modSquaresPixel   (modSquaresPixel),
        .modHighlightPixel (modHighlightPixel)
    );

    // rgb and syncs come out 2 clocks after pixelX and pixelY
    pixelColorMixer i_pixelColorMixer (
        .clk               (clk),
        .rstN              (rstN),
        .modSquaresPixel   (modSquaresPixel),
        .modHighlightPixel (modHighlightPixel),
        .active            (active),
        .hSyncRaw          (hSyncRaw),
        .vSyncRaw          (vSyncRaw),
        .rgb               (rgb),
        .hSync             (hSync),
        .vSync             (vSync)
    );

    assign pixelX = x;
    assign pixelY = y;

endmodule

// ==== src/scanTimer.sv ====
`timescale 1ns/100ps

module scanTimer import puzzleDisplayPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    output logic [xWidth-1:0] x,
    output logic [yWidth-1:0] y,
    output logic              active,
    output logic              frameStart,
    output logic              hSyncRaw,
    output logic              vSyncRaw
);

    logic lineEnd;
    logic frameEnd;

    // last clock of a line and last line of a frame
    assign lineEnd = (x == xWidth'(hTotal - 1));
    assign frameEnd = (y == yWidth'(vTotal - 1));

    // pixel counter, advances every clock
    always_ff @(posedge clk) begin
        if (!rstN) begin
            x <= '0;
        end else if (lineEnd) begin
            x <= '0;
        end else begin
            x <= x + 1'b1;
        end
    end

    // line counter, advances when the pixel counter wraps
    always_ff @(posedge clk) begin
        if (!rstN) begin
            y <= '0;
        end else if (lineEnd) begin
            if (frameEnd) begin
                y <= '0;
            end else begin
                y <= y + 1'b1;
            end
        end
    end

    // visible area flag
    assign active = (x < xWidth'(hActive)) && (y < yWidth'(vActive));

    // one cycle at the top-left pixel of each frame
    assign frameStart = (x == '0) && (y == '0);

    // sync levels, active low inside their windows
    assign hSyncRaw = !((x >= xWidth'(hSyncStart)) && (x < xWidth'(hSyncEnd)));
    assign vSyncRaw = !((y >= yWidth'(vSyncStart)) && (y < yWidth'(vSyncEnd)));

endmodule

// ==== verif/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic rstN
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // low over the first 2 rising edges, released on the second
    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

// ==== verif/puzzleDisplayTb.sv ====
`timescale 1ns/100ps

module puzzleDisplayTb import puzzleDisplayPkg::*; ();

    // the tests span about 17 frames, the watchdog allows 24
    localparam int frameCycles = hTotal * vTotal;
    localparam int watchdogFrames = 24;

    // move codes, also the bit offset from moveUp in the pulse vector
    localparam int dirUp = 0;
    localparam int dirDown = 1;
    localparam int dirLeft = 2;

    logic              clk;
    logic              rstN;
    logic              moveUp;
    logic              moveDown;
    logic              moveLeft;
    logic              moveRight;
    logic [xWidth-1:0] pixelX;
    logic [yWidth-1:0] pixelY;
    rgb12_t            rgb;
    logic              hSync;
    logic              vSync;

    int    errors = 0;
    int    seed = 82623;
    string testName = "reset";

    // reference cursor and the move waiting for the next frame start
    logic modelRow = 1'b0;
    logic modelCol = 1'b0;
    logic pendValid = 1'b0;
    int   pendDir = 0;

    // expected rgb and {hSync, vSync} per pixel, entry 1 is due now
    rgb12_t     expRgb [2] = '{12'h000, 12'h000};
    logic [1:0] expSync [2] = '{2'b11, 2'b11};

    clockGen i_clockGen (
        .clk  (clk),
        .rstN (rstN)
    );

    puzzleDisplayTop i_dut (
        .clk       (clk),
        .rstN      (rstN),
        .moveUp    (moveUp),
        .moveDown  (moveDown),
        .moveLeft  (moveLeft),
        .moveRight (moveRight),
        .pixelX    (pixelX),
        .pixelY    (pixelY),
        .rgb       (rgb),
        .hSync     (hSync),
        .vSync     (vSync)
    );

    // highlight over tile over background, black outside the visible area
    function automatic rgb12_t refColor(int px, int py, logic row, logic col);
        int cx;
        int cy;
        bit tileX;
        bit tileY;
        cx = highlightCenterBase - (col ? tileStep : 0);
        cy = highlightCenterBase - (row ? tileStep : 0);
        // open intervals, tiles at 20..110 and 130..220 on each axis
        tileX = (px > 20 && px < 110) || (px > 130 && px < 220);
        tileY = (py > 20 && py < 110) || (py > 130 && py < 220);
        if (px >= hActive || py >= vActive) begin
            return 12'h000;
        end else if (px > cx - highlightHalf && px < cx + highlightHalf &&
                     py > cy - highlightHalf && py < cy + highlightHalf) begin
            return colorHighlight;
        end else if (tileX && tileY) begin
            return colorTile;
        end else begin
            return colorBackground;
        end
    endfunction

    task automatic checkRgb(string what, rgb12_t expected, rgb12_t actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    task automatic checkSync(string what, logic expected, logic actual);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s %s: expected %b, actual %b", testName, what, expected, actual);
        end
    endtask

    task automatic checkCoord(logic [xWidth-1:0] expX, logic [yWidth-1:0] expY,
                              logic [xWidth-1:0] actX, logic [yWidth-1:0] actY);
        if (actX !== expX || actY !== expY) begin
            errors++;
            $display("ERROR %s coord: expected %0d,%0d, actual %0d,%0d",
                     testName, expX, expY, actX, actY);
        end
    endtask

    // every pixel against the rules, outputs trail the coordinate by 2 clocks
    initial begin
        forever begin
            @(negedge clk);
            if (rstN) begin
                checkRgb("rgb", expRgb[1], rgb);
                checkSync("hSync", expSync[1][1], hSync);
                checkSync("vSync", expSync[1][0], vSync);
                // saturating move taken at the frame start
                if (pixelX == '0 && pixelY == '0 && pendValid) begin
                    if (pendDir == dirUp || pendDir == dirDown) begin
                        modelRow = (pendDir == dirUp);
                    end else begin
                        modelCol = (pendDir == dirLeft);
                    end
                    pendValid = 1'b0;
                end
                expRgb[1] = expRgb[0];
                expSync[1] = expSync[0];
                expRgb[0] = refColor(int'(pixelX), int'(pixelY), modelRow, modelCol);
                expSync[0][1] = !(int'(pixelX) >= 328 && int'(pixelX) <= 375);
                expSync[0][0] = !(int'(pixelY) >= 244 && int'(pixelY) <= 245);
            end
        end
    end

    // one-cycle pulse, the model keeps it only when no move is waiting
    task automatic sendMove(int dir);
        @(posedge clk);
        {moveUp, moveDown, moveLeft, moveRight} <= 4'b1000 >> dir;
        if (!pendValid) begin
            pendValid = 1'b1;
            pendDir = dir;
        end
        @(posedge clk);
        {moveUp, moveDown, moveLeft, moveRight} <= 4'b0000;
    endtask

    task automatic waitPixel(int px, int py);
        do begin
            @(negedge clk);
        end while (!(int'(pixelX) == px && int'(pixelY) == py));
    endtask

    task automatic probeColor(int px, int py, rgb12_t expected);
        waitPixel(px, py);
        repeat (2) @(negedge clk);
        checkRgb($sformatf("rgb at %0d,%0d", px, py), expected, rgb);
    endtask

    // expected color from the model cursor at the time the pixel is scanned
    task automatic modelProbe(int px, int py);
        waitPixel(px, py);
        probeColorNow(px, py, refColor(px, py, modelRow, modelCol));
    endtask

    task automatic probeColorNow(int px, int py, rgb12_t expected);
        repeat (2) @(negedge clk);
        checkRgb($sformatf("rgb at %0d,%0d", px, py), expected, rgb);
    endtask

    task automatic resetState();
        testName = "reset";
        wait (rstN === 1'b1);
        @(negedge clk);
        checkCoord('0, '0, pixelX, pixelY);
        checkRgb("rgb", 12'h000, rgb);
        checkSync("hSync", 1'b1, hSync);
        checkSync("vSync", 1'b1, vSync);
        // row 0 and col 0 select the bottom-right tile
        probeColor(175, 65, colorTile);
        probeColor(175, 175, colorHighlight);
    endtask

    // exclusive edges of tiles and highlight, monitor covers the whole frame
    task automatic fullFrameScan();
        testName = "fullFrame";
        waitPixel(0, 0);
        probeColor(20, 65, colorBackground);
        probeColor(21, 66, colorTile);
        probeColor(175, 125, colorBackground);
        probeColor(175, 126, colorHighlight);
        probeColor(125, 175, colorBackground);
        probeColor(126, 176, colorHighlight);
        probeColor(224, 177, colorHighlight);
        probeColor(225, 178, colorBackground);
        waitPixel(0, 0);
    endtask

    task automatic moveTiming();
        testName = "moveTiming";
        waitPixel(0, 100);
        sendMove(dirLeft);
        // this frame keeps the old cursor
        probeColor(175, 175, colorHighlight);
        // next frame, bottom-left
        probeColor(65, 175, colorHighlight);
        probeColor(175, 175, colorTile);
    endtask

    task automatic saturation();
        testName = "saturation";
        waitPixel(0, 100);
        sendMove(dirUp);
        waitPixel(0, 150);
        // dropped, the up move is still pending
        sendMove(dirDown);
        probeColor(65, 65, colorHighlight);
        probeColor(65, 175, colorTile);
        waitPixel(0, 200);
        sendMove(dirUp);
        probeColor(65, 65, colorHighlight);
        probeColor(65, 175, colorTile);
    endtask

    task automatic randomMoves();
        int dir;
        testName = "random";
        for (int i = 0; i < 10; i++) begin
            waitPixel(0, 200);
            dir = $unsigned($random(seed)) % 4;
            sendMove(dir);
            modelProbe(65, 65);
            modelProbe(175, 65);
            modelProbe(65, 175);
            modelProbe(175, 175);
        end
    endtask

    initial begin
        moveUp = 1'b0;
        moveDown = 1'b0;
        moveLeft = 1'b0;
        moveRight = 1'b0;
        resetState();
        fullFrameScan();
        moveTiming();
        saturation();
        randomMoves();
        $display("run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(watchdogFrames * frameCycles * 20);
        $display("timeout: tests still running after %0d frames, %0d errors so far",
                 watchdogFrames, errors);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== verif/puzzleDisplay_assert.sv ====
`timescale 1ns/100ps

module puzzleDisplayAssert import puzzleDisplayPkg::*; (
    input logic         clk,
    input logic         rstN,
    input logic         hSync,
    input logic         frameStart,
    input cursorState_t state,
    input logic         modRow,
    input logic         modCol
);

    // length of the current hsync low stretch
    logic [8:0] hLowCount;

    always_ff @(posedge clk) begin
        if (!rstN || hSync) begin
            hLowCount <= '0;
        end else begin
            hLowCount <= hLowCount + 1'b1;
        end
    end

    // when hsync returns high the low stretch was exactly 48 clocks
    assert property (@(posedge clk) disable iff (!rstN)
        $rose(hSync) |-> hLowCount == 9'(hSyncEnd - hSyncStart))
        else $error("hSync low width was %0d clocks", hLowCount);

    // the selected tile changes only right after an apply cycle
    assert property (@(posedge clk) disable iff (!rstN)
        !$stable({modRow, modCol}) |-> $past(state) == cursorApply)
        else $error("cursor changed outside the apply cycle");

    // a pending move leaves its state only on a frame start
    assert property (@(posedge clk) disable iff (!rstN)
        ($past(state) == cursorPending && state != cursorPending) |-> $past(frameStart))
        else $error("cursor FSM left pending without a frame start");

endmodule

bind puzzleDisplayTop puzzleDisplayAssert i_assert (
    .clk        (clk),
    .rstN       (rstN),
    .hSync      (hSync),
    .frameStart (frameStart),
    .state      (i_cursorControl.state),
    .modRow     (modRow),
    .modCol     (modCol)
);
